// File: common/rob_macros.svh
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// --------------------
// buffer geometry
// --------------------

// number of reorder buffer entries
`define ROB_DEPTH 32

// slot index width, pointers carry one extra wrap bit
`define ROB_IDX_W 5

// --------------------
// rename and branch state
// --------------------

`define PRF_IDX_W 6 // physical register tag
`define LRF_IDX_W 5 // architectural register number

// one bit per in-flight branch
`define BR_MASK_W 4

// free list head snapshot, used to roll the free list back
`define FL_HEAD_W 5

// program counter and branch target width
`define XLEN 64

`endif

// File: common/rob_pkg.sv
`include "rob_macros.svh"

package rob_pkg;

	// --------------------
	// indices and tags
	// --------------------

	typedef logic [`ROB_IDX_W-1:0] rob_idx_t; // slot number
	typedef logic [`ROB_IDX_W:0]   rob_ptr_t; // slot number plus wrap bit

	typedef logic [`PRF_IDX_W-1:0] prf_tag_t;
	typedef logic [`LRF_IDX_W-1:0] areg_t;
	typedef logic [`BR_MASK_W-1:0] br_mask_t;
	typedef logic [`FL_HEAD_W-1:0] fl_head_t;
	typedef logic [`XLEN-1:0]      addr_t;

	// --------------------
	// entry payloads
	// --------------------

	// what the head hands to the free list and the architectural map
	typedef struct packed {
		prf_tag_t old_tag; // previous mapping, freed at retire
		prf_tag_t new_tag; // tag that becomes architectural
		areg_t    areg;
		addr_t    pc;
	} retire_payload_t;

	// prediction and snapshot needed for early recovery
	typedef struct packed {
		logic     br_flag;  // entry is a branch
		logic     pretaken; // predicted direction
		addr_t    target;   // predicted target
		br_mask_t mask;
		fl_head_t fl_head;
	} branch_payload_t;

endpackage

// File: hw/rob/rob_ptr_ctrl.sv
`timescale 1ns/100ps
`include "rob_macros.svh"

module rob_ptr_ctrl import rob_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     dispatch_en_i,
	input  logic     retire_i,
	input  logic     rollback_i,
	input  rob_ptr_t rollback_idx_i, // pointer of the mispredicted branch
	output rob_ptr_t head_o,
	output rob_ptr_t tail_o,
	output logic     empty_o,
	output logic     stall_o
);

	rob_ptr_t head_r;
	rob_ptr_t tail_r;
	logic     full;

	assign head_o = head_r;
	assign tail_o = tail_r;

	// same slot, wrap bits tell full from empty
	assign empty_o = (head_r == tail_r);
	assign full    = (head_r[`ROB_IDX_W-1:0] == tail_r[`ROB_IDX_W-1:0]) &&
		(head_r[`ROB_IDX_W] != tail_r[`ROB_IDX_W]);

	// a retiring head frees the slot the dispatch is about to take
	assign stall_o = full && !retire_i;

	// --------------------
	// pointer update
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
		end else begin
			if (retire_i)
				head_r <= head_r + rob_ptr_t'(1);

			if (rollback_i)
				tail_r <= rollback_idx_i + rob_ptr_t'(1); // keep the branch, drop younger
			else if (dispatch_en_i)
				tail_r <= tail_r + rob_ptr_t'(1);
		end
	end

	// upstream must hold off while the buffer is full
	assert property (@(posedge clk) disable iff (rst) stall_o |-> !dispatch_en_i)
		else $error("dispatch while the reorder buffer is stalled");

endmodule

// File: hw/rob/rob_entry_ram.sv
`timescale 1ns/100ps
`include "rob_macros.svh"

module rob_entry_ram import rob_pkg::*; #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     wr_en_i,
	input  rob_idx_t wr_idx_i,
	input  payload_t wr_data_i,
	input  rob_idx_t head_idx_i,
	input  rob_idx_t rd_idx_i,
	output payload_t head_data_o,
	output payload_t rd_data_o
);

	payload_t mem_r [`ROB_DEPTH];

	// one write port at the tail
	always_ff @(posedge clk) begin
		if (rst)
			mem_r <= '{default: '0};
		else if (wr_en_i)
			mem_r[wr_idx_i] <= wr_data_i;
	end

	// --------------------
	// read ports
	// --------------------

	assign head_data_o = mem_r[head_idx_i]; // oldest entry
	assign rd_data_o   = mem_r[rd_idx_i];   // random lookup

endmodule

// File: hw/rob/rob_commit_ctrl.sv
`timescale 1ns/100ps
`include "rob_macros.svh"

module rob_commit_ctrl import rob_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            dispatch_en_i,
	input  rob_idx_t        tail_idx_i,
	input  rob_idx_t        head_idx_i,
	input  logic            empty_i,
	input  logic            fu_done_i,
	input  rob_idx_t        fu_idx_i,
	input  logic            fu_br_taken_i,
	input  retire_payload_t head_payload_i,
	input  addr_t           npc_pc_i,
	output logic            retire_rdy_o,
	output prf_tag_t        retire_old_tag_o,
	output prf_tag_t        retire_tag_o,
	output areg_t           retire_areg_o,
	output addr_t           npc_o
);

	logic [`ROB_DEPTH-1:0][1:0] status_r; // {branch taken, done} per slot
	logic                       occupied; // completion index lies between head and tail

	// --------------------
	// completion status
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			status_r <= '0;
		end else begin
			if (dispatch_en_i)
				status_r[tail_idx_i] <= 2'b00; // fresh entry starts not done
			if (fu_done_i)
				status_r[fu_idx_i] <= {fu_br_taken_i, 1'b1};
		end
	end

	// head retires as soon as it is done
	assign retire_rdy_o = status_r[head_idx_i][0] && !empty_i;

	// zero toward the free list and arch map unless retiring
	assign retire_old_tag_o = retire_rdy_o ? head_payload_i.old_tag : '0;
	assign retire_tag_o     = retire_rdy_o ? head_payload_i.new_tag : '0;
	assign retire_areg_o    = retire_rdy_o ? head_payload_i.areg : '0;

	assign npc_o = npc_pc_i + addr_t'(4); // fall-through pc for the branch unit

	// circular range check, head == tail with non-empty means full
	always_comb begin
		if (empty_i)
			occupied = 1'b0;
		else if (head_idx_i < tail_idx_i)
			occupied = (fu_idx_i >= head_idx_i) && (fu_idx_i < tail_idx_i);
		else
			occupied = (fu_idx_i >= head_idx_i) || (fu_idx_i < tail_idx_i);
	end

	assert property (@(posedge clk) disable iff (rst) fu_done_i |-> occupied)
		else $error("completion to an unallocated reorder buffer slot");

endmodule

// File: hw/rob/rob_branch_check.sv
`timescale 1ns/100ps

module rob_branch_check import rob_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            br_resolve_i,
	input  logic            br_taken_i,
	input  addr_t           br_target_i, // resolved target
	input  branch_payload_t entry_i,     // stored prediction at the resolved index
	output logic            recovery_rdy_o,
	output logic            br_right_o,
	output br_mask_t        recovery_mask_o,
	output fl_head_t        recovery_fl_head_o
);

	logic is_branch;
	logic mispredict;
	logic mark_r; // low for one cycle after a recovery

	// --------------------
	// prediction check
	// --------------------
	assign is_branch  = br_resolve_i && entry_i.br_flag;
	assign mispredict = (entry_i.pretaken != br_taken_i) || (entry_i.target != br_target_i);

	assign recovery_rdy_o = is_branch && mispredict && mark_r;
	assign br_right_o     = is_branch && !mispredict;

	// snapshot taken at dispatch of this branch
	assign recovery_mask_o    = entry_i.mask;
	assign recovery_fl_head_o = entry_i.fl_head;

	// back-to-back recovery would act on an already squashed path
	always_ff @(posedge clk) begin
		if (rst)
			mark_r <= 1'b1;
		else
			mark_r <= !recovery_rdy_o;
	end

endmodule

// File: hw/rob/rob_top.sv
`timescale 1ns/100ps
`include "rob_macros.svh"

module rob_top import rob_pkg::*; (
	input  logic     clk,
	input  logic     rst,

	// dispatch
	input  logic     dispatch_en_i,
	input  prf_tag_t fl_tag_i,  // new tag from the free list
	input  prf_tag_t map_tag_i, // old tag from the map table
	input  areg_t    areg_i,
	input  addr_t    pc_i,
	input  logic     br_flag_i,
	input  logic     br_pretaken_i,
	input  addr_t    br_target_i,
	input  br_mask_t br_mask_i,
	input  fl_head_t fl_head_i,

	// completion
	input  logic     fu_done_i,
	input  rob_ptr_t fu_idx_i,
	input  logic     fu_br_taken_i,

	// branch resolution
	input  logic     br_resolve_i,
	input  rob_ptr_t br_idx_i,
	input  logic     br_taken_i,
	input  addr_t    br_target_i_res,

	// npc read for the branch unit
	input  rob_ptr_t npc_idx_i,

	output rob_ptr_t tail_idx_o,
	output logic     stall_o,
	output logic     retire_rdy_o,
	output prf_tag_t retire_old_tag_o,
	output prf_tag_t retire_tag_o,
	output areg_t    retire_areg_o,
	output addr_t    npc_o,
	output logic     br_recovery_rdy_o,
	output logic     br_right_o,
	output br_mask_t recovery_mask_o,
	output fl_head_t recovery_fl_head_o
);

	rob_ptr_t        head_ptr;
	logic            empty;
	retire_payload_t retire_wr_data;
	branch_payload_t branch_wr_data;
	retire_payload_t retire_head_data;
	retire_payload_t npc_entry;
	branch_payload_t branch_entry;

	assign retire_wr_data = '{old_tag: map_tag_i, new_tag: fl_tag_i, areg: areg_i, pc: pc_i};
	assign branch_wr_data = '{br_flag: br_flag_i, pretaken: br_pretaken_i,
		target: br_target_i, mask: br_mask_i, fl_head: fl_head_i};

	// --------------------
	// pointers
	// --------------------
	rob_ptr_ctrl u_ptr (
		.clk            (clk),
		.rst            (rst),
		.dispatch_en_i  (dispatch_en_i),
		.retire_i       (retire_rdy_o),
		.rollback_i     (br_recovery_rdy_o), // recovery squashes everything after the branch
		.rollback_idx_i (br_idx_i),
		.head_o         (head_ptr),
		.tail_o         (tail_idx_o),
		.empty_o        (empty),
		.stall_o        (stall_o)
	);

	// --------------------
	// entry storage
	// --------------------
	rob_entry_ram #(.payload_t(retire_payload_t)) u_retire_ram (
		.clk         (clk),
		.rst         (rst),
		.wr_en_i     (dispatch_en_i),
		.wr_idx_i    (tail_idx_o[`ROB_IDX_W-1:0]),
		.wr_data_i   (retire_wr_data),
		.head_idx_i  (head_ptr[`ROB_IDX_W-1:0]),
		.rd_idx_i    (npc_idx_i[`ROB_IDX_W-1:0]),
		.head_data_o (retire_head_data),
		.rd_data_o   (npc_entry)
	);

	// head port unused here, branches are looked up by index only
	rob_entry_ram #(.payload_t(branch_payload_t)) u_branch_ram (
		.clk         (clk),
		.rst         (rst),
		.wr_en_i     (dispatch_en_i),
		.wr_idx_i    (tail_idx_o[`ROB_IDX_W-1:0]),
		.wr_data_i   (branch_wr_data),
		.head_idx_i  (head_ptr[`ROB_IDX_W-1:0]),
		.rd_idx_i    (br_idx_i[`ROB_IDX_W-1:0]),
		.head_data_o (),
		.rd_data_o   (branch_entry)
	);

	// --------------------
	// retire and branch
	// --------------------
	rob_commit_ctrl u_commit (
		.clk              (clk),
		.rst              (rst),
		.dispatch_en_i    (dispatch_en_i),
		.tail_idx_i       (tail_idx_o[`ROB_IDX_W-1:0]),
		.head_idx_i       (head_ptr[`ROB_IDX_W-1:0]),
		.empty_i          (empty),
		.fu_done_i        (fu_done_i),
		.fu_idx_i         (fu_idx_i[`ROB_IDX_W-1:0]),
		.fu_br_taken_i    (fu_br_taken_i),
		.head_payload_i   (retire_head_data),
		.npc_pc_i         (npc_entry.pc),
		.retire_rdy_o     (retire_rdy_o),
		.retire_old_tag_o (retire_old_tag_o),
		.retire_tag_o     (retire_tag_o),
		.retire_areg_o    (retire_areg_o),
		.npc_o            (npc_o)
	);

	rob_branch_check u_branch (
		.clk                (clk),
		.rst                (rst),
		.br_resolve_i       (br_resolve_i),
		.br_taken_i         (br_taken_i),
		.br_target_i        (br_target_i_res),
		.entry_i            (branch_entry),
		.recovery_rdy_o     (br_recovery_rdy_o),
		.br_right_o         (br_right_o),
		.recovery_mask_o    (recovery_mask_o),
		.recovery_fl_head_o (recovery_fl_head_o)
	);

endmodule

// File: verification/rob_tests.svh
// every task starts just after a falling edge and returns on one

// --------------------
// stimulus helpers
// --------------------
task automatic dispatch_entry(input logic is_br, input logic pretaken, input addr_t target);
	retire_payload_t r;
	branch_payload_t b;
	r.old_tag  = prf_tag_t'($random(seed));
	r.new_tag  = prf_tag_t'($random(seed));
	r.areg     = areg_t'($random(seed));
	r.pc       = {$random(seed), $random(seed)};
	b.br_flag  = is_br;
	b.pretaken = pretaken;
	b.target   = target;
	b.mask     = br_mask_t'($random(seed));
	b.fl_head  = fl_head_t'($random(seed));
	dispatch_en_i = 1'b1;
	map_tag_i     = r.old_tag;
	fl_tag_i      = r.new_tag;
	areg_i        = r.areg;
	pc_i          = r.pc;
	br_flag_i     = b.br_flag;
	br_pretaken_i = b.pretaken;
	br_target_i   = b.target;
	br_mask_i     = b.mask;
	fl_head_i     = b.fl_head;
	#1;
	compare_bit("stall at dispatch", stall_o, 1'b0);
	compare_ptr("dispatch slot", tail_idx_o, model_tail);
	model_ret[model_tail[`ROB_IDX_W-1:0]] = r;
	model_br[model_tail[`ROB_IDX_W-1:0]]  = b;
	order_q.push_back(r);
	model_tail = model_tail + rob_ptr_t'(1);
	@(negedge clk);
	dispatch_en_i = 1'b0;
endtask

task automatic complete_entry(input rob_ptr_t idx);
	fu_done_i     = 1'b1;
	fu_idx_i      = idx;
	fu_br_taken_i = 1'b0;
	@(negedge clk);
	fu_done_i = 1'b0;
endtask

// checks the retirement of the current cycle without advancing time once ready
task automatic expect_retire();
	retire_payload_t exp;
	int              waited;
	waited = 0;
	while (retire_rdy_o !== 1'b1) begin
		if (waited == RETIRE_WAIT)
			abort_run($sformatf("retirement missing after %0d cycles of waiting", RETIRE_WAIT));
		@(negedge clk);
		waited++;
	end
	if (order_q.size() == 0)
		abort_run("retirement seen while the model holds no entry");
	exp = order_q.pop_front();
	compare_tag("retire old tag", retire_old_tag_o, exp.old_tag);
	compare_tag("retire new tag", retire_tag_o, exp.new_tag);
	compare_areg("retire areg", retire_areg_o, exp.areg);
	model_head = model_head + rob_ptr_t'(1);
endtask

// completes from the youngest down to the head and then follows the retirements
task automatic drain_all();
	int count;
	count = int'(rob_ptr_t'(model_tail - model_head));
	for (int i = count - 1; i >= 1; i--) begin
		complete_entry(model_head + rob_ptr_t'(i));
		compare_bit("retire before head is done", retire_rdy_o, 1'b0);
	end
	if (count > 0)
		complete_entry(model_head);
	for (int i = 0; i < count; i++) begin
		expect_retire();
		@(negedge clk);
	end
	compare_bit("retire when empty", retire_rdy_o, 1'b0);
	compare_tag("retire tag when idle", retire_tag_o, '0);
endtask

task automatic resolve_branch(input rob_ptr_t idx, input logic taken, input addr_t target,
	input logic exp_right, input logic exp_recover);
	branch_payload_t b;
	b               = model_br[idx[`ROB_IDX_W-1:0]];
	br_resolve_i    = 1'b1;
	br_idx_i        = idx;
	br_taken_i      = taken;
	br_target_i_res = target;
	#1;
	compare_bit("branch right", br_right_o, exp_right);
	compare_bit("recovery", br_recovery_rdy_o, exp_recover);
	if (exp_recover) begin
		compare_mask("recovery mask", recovery_mask_o, b.mask);
		compare_fl_head("recovery free list head", recovery_fl_head_o, b.fl_head);
		model_tail = idx + rob_ptr_t'(1); // younger entries are squashed
		while (order_q.size() > int'(rob_ptr_t'(model_tail - model_head)))
			order_q.delete(order_q.size() - 1);
	end
	@(negedge clk);
	br_resolve_i = 1'b0;
endtask

// --------------------
// directed tests
// --------------------
task automatic test_reset_and_dispatch();
	compare_bit("stall after reset", stall_o, 1'b0);
	compare_bit("retire after reset", retire_rdy_o, 1'b0);
	compare_bit("recovery after reset", br_recovery_rdy_o, 1'b0);
	compare_bit("branch right after reset", br_right_o, 1'b0);
	for (int i = 0; i < 3; i++) begin
		compare_ptr("tail after reset", tail_idx_o, rob_ptr_t'(i));
		dispatch_entry(1'b0, 1'b0, '0);
	end
endtask

task automatic test_in_order_retire();
	for (int i = 0; i < 3; i++)
		dispatch_entry(1'b0, 1'b0, '0);
	drain_all();
endtask

task automatic test_full_stall();
	for (int i = 0; i < `ROB_DEPTH; i++)
		dispatch_entry(1'b0, 1'b0, '0);
	compare_bit("stall when full", stall_o, 1'b1);
	complete_entry(model_head);
	compare_bit("stall while head retires", stall_o, 1'b0);
	expect_retire();
	dispatch_entry(1'b0, 1'b0, '0); // same cycle as the retirement
	compare_bit("stall after shared cycle", stall_o, 1'b1);
	compare_ptr("tail after shared cycle", tail_idx_o, model_tail);
	drain_all();
endtask

task automatic test_npc_read();
	rob_ptr_t idx;
	for (int i = 0; i < 4; i++)
		dispatch_entry(1'b0, 1'b0, '0);
	for (int i = 0; i < 4; i++) begin
		idx       = model_head + rob_ptr_t'(i);
		npc_idx_i = idx;
		#1;
		compare_addr("npc", npc_o, model_ret[idx[`ROB_IDX_W-1:0]].pc + addr_t'(4));
		@(negedge clk);
	end
	drain_all();
endtask

task automatic test_branch_recovery();
	addr_t    tgt_a;
	addr_t    tgt_b;
	rob_ptr_t br_a;
	rob_ptr_t br_b;
	tgt_a = {$random(seed), $random(seed)};
	tgt_b = {$random(seed), $random(seed)};
	dispatch_entry(1'b0, 1'b0, '0);
	br_a = model_tail;
	dispatch_entry(1'b1, 1'b1, tgt_a);
	br_b = model_tail;
	dispatch_entry(1'b1, 1'b0, tgt_b);
	dispatch_entry(1'b0, 1'b0, '0);
	resolve_branch(br_a, 1'b1, tgt_a, 1'b1, 1'b0); // predicted right
	resolve_branch(br_b, 1'b1, tgt_b, 1'b0, 1'b1); // wrong direction
	compare_ptr("tail after direction miss", tail_idx_o, br_b + rob_ptr_t'(1));
	br_a = model_tail;
	dispatch_entry(1'b1, 1'b1, tgt_a);
	resolve_branch(br_a, 1'b1, tgt_a ^ addr_t'(16), 1'b0, 1'b1); // wrong target
	compare_ptr("tail after target miss", tail_idx_o, br_a + rob_ptr_t'(1));
	dispatch_entry(1'b0, 1'b0, '0);
	drain_all();
endtask

task automatic test_back_to_back_recovery();
	addr_t    tgt;
	rob_ptr_t br_first;
	rob_ptr_t br_second;
	tgt      = {$random(seed), $random(seed)};
	br_first = model_tail;
	dispatch_entry(1'b1, 1'b0, tgt);
	br_second = model_tail;
	dispatch_entry(1'b1, 1'b0, tgt);
	dispatch_entry(1'b0, 1'b0, '0);
	resolve_branch(br_first, 1'b1, tgt, 1'b0, 1'b1);
	resolve_branch(br_second, 1'b1, tgt, 1'b0, 1'b0); // suppressed by the mark
	compare_ptr("tail after suppressed recovery", tail_idx_o, br_first + rob_ptr_t'(1));
	resolve_branch(br_first, 1'b1, tgt, 1'b0, 1'b1);  // mark has cleared again
	dispatch_entry(1'b0, 1'b0, '0);
	drain_all();
endtask

// File: verification/tb_rob.sv
`timescale 1ns/100ps
`include "rob_macros.svh"

module tb_rob import rob_pkg::*; ();

	localparam int WATCHDOG_CYCLES = 2000; // whole sequence runs in a few hundred cycles
	localparam int RETIRE_WAIT     = 4;    // head retires one cycle after completion

	logic     clk;
	logic     rst;
	logic     dispatch_en_i;
	prf_tag_t fl_tag_i;
	prf_tag_t map_tag_i;
	areg_t    areg_i;
	addr_t    pc_i;
	logic     br_flag_i;
	logic     br_pretaken_i;
	addr_t    br_target_i;
	br_mask_t br_mask_i;
	fl_head_t fl_head_i;
	logic     fu_done_i;
	rob_ptr_t fu_idx_i;
	logic     fu_br_taken_i;
	logic     br_resolve_i;
	rob_ptr_t br_idx_i;
	logic     br_taken_i;
	addr_t    br_target_i_res;
	rob_ptr_t npc_idx_i;

	rob_ptr_t tail_idx_o;
	logic     stall_o;
	logic     retire_rdy_o;
	prf_tag_t retire_old_tag_o;
	prf_tag_t retire_tag_o;
	areg_t    retire_areg_o;
	addr_t    npc_o;
	logic     br_recovery_rdy_o;
	logic     br_right_o;
	br_mask_t recovery_mask_o;
	fl_head_t recovery_fl_head_o;

	// --------------------
	// reference model
	// --------------------
	retire_payload_t model_ret [`ROB_DEPTH]; // by slot
	branch_payload_t model_br [`ROB_DEPTH];
	retire_payload_t order_q [$];            // expected retire order with the oldest first
	rob_ptr_t        model_head;
	rob_ptr_t        model_tail;
	integer          seed = 66;

	rob_top i_dut (
		.clk                (clk),
		.rst                (rst),
		.dispatch_en_i      (dispatch_en_i),
		.fl_tag_i           (fl_tag_i),
		.map_tag_i          (map_tag_i),
		.areg_i             (areg_i),
		.pc_i               (pc_i),
		.br_flag_i          (br_flag_i),
		.br_pretaken_i      (br_pretaken_i),
		.br_target_i        (br_target_i),
		.br_mask_i          (br_mask_i),
		.fl_head_i          (fl_head_i),
		.fu_done_i          (fu_done_i),
		.fu_idx_i           (fu_idx_i),
		.fu_br_taken_i      (fu_br_taken_i),
		.br_resolve_i       (br_resolve_i),
		.br_idx_i           (br_idx_i),
		.br_taken_i         (br_taken_i),
		.br_target_i_res    (br_target_i_res),
		.npc_idx_i          (npc_idx_i),
		.tail_idx_o         (tail_idx_o),
		.stall_o            (stall_o),
		.retire_rdy_o       (retire_rdy_o),
		.retire_old_tag_o   (retire_old_tag_o),
		.retire_tag_o       (retire_tag_o),
		.retire_areg_o      (retire_areg_o),
		.npc_o              (npc_o),
		.br_recovery_rdy_o  (br_recovery_rdy_o),
		.br_right_o         (br_right_o),
		.recovery_mask_o    (recovery_mask_o),
		.recovery_fl_head_o (recovery_fl_head_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// --------------------
	// failure and compare
	// --------------------
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string msg);
		abort_run($sformatf("[ERROR] %0t: %s", $time, msg));
	endtask

	task automatic compare_tag(input string what, input prf_tag_t got, input prf_tag_t exp);
		if (got !== exp)
			report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
	endtask

	task automatic compare_areg(input string what, input areg_t got, input areg_t exp);
		if (got !== exp)
			report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
	endtask

	task automatic compare_addr(input string what, input addr_t got, input addr_t exp);
		if (got !== exp)
			report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
	endtask

	task automatic compare_mask(input string what, input br_mask_t got, input br_mask_t exp);
		if (got !== exp)
			report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
	endtask

	task automatic compare_fl_head(input string what, input fl_head_t got, input fl_head_t exp);
		if (got !== exp)
			report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
	endtask

	task automatic compare_ptr(input string what, input rob_ptr_t got, input rob_ptr_t exp);
		if (got !== exp)
			report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
	endtask

	task automatic compare_bit(input string what, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
	endtask

	task automatic idle_inputs();
		dispatch_en_i   = 1'b0;
		fl_tag_i        = '0;
		map_tag_i       = '0;
		areg_i          = '0;
		pc_i            = '0;
		br_flag_i       = 1'b0;
		br_pretaken_i   = 1'b0;
		br_target_i     = '0;
		br_mask_i       = '0;
		fl_head_i       = '0;
		fu_done_i       = 1'b0;
		fu_idx_i        = '0;
		fu_br_taken_i   = 1'b0;
		br_resolve_i    = 1'b0;
		br_idx_i        = '0;
		br_taken_i      = 1'b0;
		br_target_i_res = '0;
		npc_idx_i       = '0;
	endtask

	`include "rob_tests.svh"

	// catches a sequence that stops making progress
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run($sformatf("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES));
	end

	initial begin
		idle_inputs();
		model_head = '0;
		model_tail = '0;
		rst = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_reset_and_dispatch();
		test_in_order_retire();
		test_full_stall();
		test_npc_read();
		test_branch_recovery();
		test_back_to_back_recovery();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+common
+incdir+verification
common/rob_pkg.sv
hw/rob/rob_ptr_ctrl.sv
hw/rob/rob_entry_ram.sv
hw/rob/rob_commit_ctrl.sv
hw/rob/rob_branch_check.sv
hw/rob/rob_top.sv
verification/tb_rob.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_rob
RTL_TOP    := rob_top
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := *** PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
